//--- vlog.f
logic/icache_pkg.sv
logic/cache_array_if.sv
logic/icache_tag_array.sv
logic/icache_data_array.sv
logic/icache_ctrl.sv
logic/icache_top.sv
tests/icache_tb.sv

//--- Bender.yml
package:
  name: icache

sources:
  - logic/icache_pkg.sv
  - logic/cache_array_if.sv
  - logic/icache_tag_array.sv
  - logic/icache_data_array.sv
  - logic/icache_ctrl.sv
  - logic/icache_top.sv
  - target: test
    files:
      - tests/icache_tb.sv

//--- tests/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;
    import icache_pkg::*;

    localparam int TIMEOUT = 60;

    logic              clk;
    logic              reset;
    logic              fetch_en_i;
    logic [31:0]       fetch_addr_i;
    logic              uncache_i;
    logic              flush_i;
    logic              stall_o;
    logic              inst_valid_o;
    logic [31:0]       inst_o;
    logic [31:0]       inst_addr_o;
    logic              rd_req_o;
    logic [31:0]       rd_addr_o;
    logic              ret_valid_i;
    logic [LINE_W-1:0] ret_data_i;
    logic              uc_ren_o;
    logic [31:0]       uc_addr_o;
    logic              uc_rvalid_i;
    logic [31:0]       uc_rdata_i;
    logic              cacop_en_i;
    cacop_op_t         cacop_mode_i;
    logic [31:0]       cacop_addr_i;

    int          errors;
    int          checks;
    int          req_cycles;
    int          uc_cycles;
    int          valid_cycles;
    logic [31:0] last_rd_addr;
    logic [31:0] last_uc_addr;
    logic [31:0] lfsr_q;
    logic        mem_busy;
    int          mem_cnt;
    logic [31:0] mem_addr;
    logic        uc_busy;
    int          uc_cnt;
    logic [31:0] uc_req_addr;

    icache_top u_icache_top (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = (v << 1) | int'(lfsr_q[0]);
        end
        return v;
    endfunction

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'h5A5A_0000;
    endfunction

    function automatic logic [31:0] uc_word(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ 32'hC3C3_0000;
    endfunction

    function automatic logic [LINE_W-1:0] make_line(input logic [31:0] addr);
        logic [LINE_W-1:0] l;
        for (int b = 0; b < BANKS; b++) begin
            l[b*32 +: 32] = mem_word({addr[31:5], 3'(b), 2'b00});
        end
        return l;
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        return {20'(tag), 7'(index), 3'(word), 2'b00};
    endfunction

    // line memory, 3 to 6 cycles
    always @(posedge clk) begin
        ret_valid_i <= 1'b0;
        if (reset) begin
            mem_busy <= 1'b0;
        end else if (mem_busy) begin
            if (mem_cnt == 0) begin
                ret_valid_i <= 1'b1;
                ret_data_i  <= make_line(mem_addr);
                mem_busy    <= 1'b0;
            end else begin
                mem_cnt <= mem_cnt - 1;
            end
        end else if (rd_req_o) begin
            mem_busy <= 1'b1;
            mem_addr <= rd_addr_o;
            mem_cnt  <= 2 + rand_bits(2);
        end
    end

    always @(posedge clk) begin
        uc_rvalid_i <= 1'b0;
        if (reset) begin
            uc_busy <= 1'b0;
        end else if (uc_busy) begin
            if (uc_cnt == 0) begin
                uc_rvalid_i <= 1'b1;
                uc_rdata_i  <= uc_word(uc_req_addr);
                uc_busy     <= 1'b0;
            end else begin
                uc_cnt <= uc_cnt - 1;
            end
        end else if (uc_ren_o) begin
            uc_busy     <= 1'b1;
            uc_cnt      <= 1;
            uc_req_addr <= uc_addr_o;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (rd_req_o) begin
                req_cycles++;
                last_rd_addr = rd_addr_o;
            end
            if (uc_ren_o) begin
                uc_cycles++;
                last_uc_addr = uc_addr_o;
            end
            if (inst_valid_o) valid_cycles++;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timed out while waiting for %s", what);
    endtask

    task automatic finish_test(input string name, input int e0);
        $display("%s finished with %0d errors", name, errors - e0);
    endtask

    // holds the fetch until accepted, returns on the acceptance edge
    task automatic issue_fetch(input logic [31:0] addr, input logic uc);
        int n;
        @(posedge clk);
        fetch_en_i   <= 1'b1;
        fetch_addr_i <= addr;
        uncache_i    <= uc;
        n = 0;
        @(negedge clk);
        while (stall_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stall_o) timed_out("fetch acceptance");
        @(posedge clk);
        fetch_en_i <= 1'b0;
    endtask

    task automatic wait_inst(input logic [31:0] addr, input logic [31:0] exp, output int lat);
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!inst_valid_o && lat < TIMEOUT);
        if (!inst_valid_o) begin
            timed_out("inst_valid_o");
        end else begin
            check("inst_o", inst_o, exp);
            check("inst_addr_o", inst_addr_o, addr);
            check("stall_o", stall_o, 1'b0);
        end
    endtask

    task automatic fetch_and_check(input logic [31:0] addr, input logic uc, input logic miss);
        int r0;
        int u0;
        int lat;
        r0 = req_cycles;
        u0 = uc_cycles;
        issue_fetch(addr, uc);
        wait_inst(addr, uc ? uc_word(addr) : mem_word(addr), lat);
        @(posedge clk);
        check("rd_req_o seen", req_cycles != r0, miss && !uc);
        check("uc_ren_o seen", uc_cycles != u0, uc);
        if (!miss && !uc) check("hit latency", lat, 1);
    endtask

    task automatic run_cacop(input cacop_op_t op, input logic [31:0] addr);
        int n;
        int s;
        @(posedge clk);
        cacop_en_i   <= 1'b1;
        cacop_mode_i <= op;
        cacop_addr_i <= addr;
        n = 0;
        @(negedge clk);
        while (stall_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stall_o) timed_out("maintenance acceptance");
        @(posedge clk);
        cacop_en_i <= 1'b0;
        s = 0;
        @(negedge clk);
        while (stall_o && s < TIMEOUT) begin
            @(negedge clk);
            s++;
        end
        check("stall_o cycles", s, 2);
        @(posedge clk);
    endtask

    task automatic miss_then_hit();
        int e0;
        e0 = errors;
        @(negedge clk);
        check("stall_o after reset", stall_o, 1'b0);
        check("inst_valid_o after reset", inst_valid_o, 1'b0);
        check("rd_req_o after reset", rd_req_o, 1'b0);
        check("uc_ren_o after reset", uc_ren_o, 1'b0);
        fetch_and_check(make_addr(16'h1234, 10, 3), 1'b0, 1'b1);
        check("rd_addr_o", last_rd_addr, make_addr(16'h1234, 10, 3));
        fetch_and_check(make_addr(16'h1234, 10, 6), 1'b0, 1'b0);
        finish_test("miss_then_hit", e0);
    endtask

    task automatic replacement_lru();
        int e0;
        e0 = errors;
        fetch_and_check(make_addr(16'h00A0, 20, 1), 1'b0, 1'b1);
        fetch_and_check(make_addr(16'h00B0, 20, 2), 1'b0, 1'b1);
        fetch_and_check(make_addr(16'h00A0, 20, 4), 1'b0, 1'b0);
        fetch_and_check(make_addr(16'h00C0, 20, 5), 1'b0, 1'b1);  // evicts B
        fetch_and_check(make_addr(16'h00A0, 20, 0), 1'b0, 1'b0);
        fetch_and_check(make_addr(16'h00B0, 20, 7), 1'b0, 1'b1);
        finish_test("replacement_lru", e0);
    endtask

    task automatic uncached_fetch();
        int e0;
        e0 = errors;
        fetch_and_check(make_addr(16'h0300, 30, 2), 1'b1, 1'b0);
        check("uc_addr_o", last_uc_addr, make_addr(16'h0300, 30, 2));
        fetch_and_check(make_addr(16'h0300, 30, 2), 1'b0, 1'b1);  // nothing allocated
        finish_test("uncached_fetch", e0);
    endtask

    task automatic maintenance_ops();
        int e0;
        e0 = errors;
        for (int i = 40; i <= 42; i++) begin
            fetch_and_check(make_addr(16'h0400, i, 0), 1'b0, 1'b1);  // way 0
            fetch_and_check(make_addr(16'h0500, i, 1), 1'b0, 1'b1);  // way 1
        end
        run_cacop(CACOP_HIT_INV, make_addr(16'h0400, 40, 5));
        fetch_and_check(make_addr(16'h0500, 40, 2), 1'b0, 1'b0);
        fetch_and_check(make_addr(16'h0400, 40, 3), 1'b0, 1'b1);
        run_cacop(CACOP_IDX_INV, make_addr(16'h0000, 41, 0) | 32'h1);
        fetch_and_check(make_addr(16'h0400, 41, 4), 1'b0, 1'b0);
        fetch_and_check(make_addr(16'h0500, 41, 6), 1'b0, 1'b1);
        run_cacop(CACOP_INIT, make_addr(16'h0000, 42, 0));
        fetch_and_check(make_addr(16'h0400, 42, 1), 1'b0, 1'b1);
        fetch_and_check(make_addr(16'h0500, 42, 7), 1'b0, 1'b1);
        fetch_and_check(make_addr(16'h0500, 40, 0), 1'b0, 1'b0);
        finish_test("maintenance_ops", e0);
    endtask

    task automatic flush_during_miss();
        int e0;
        int v0;
        int n;
        e0 = errors;
        v0 = valid_cycles;
        issue_fetch(make_addr(16'h0600, 60, 3), 1'b0);
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!rd_req_o && n < TIMEOUT);
        if (!rd_req_o) timed_out("rd_req_o");
        @(posedge clk);
        flush_i <= 1'b1;
        @(posedge clk);
        flush_i <= 1'b0;
        n = 0;
        @(negedge clk);
        while (stall_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (stall_o) timed_out("stall_o to fall after the flush");
        check("memory busy when stall_o fell", mem_busy, 1'b0);
        @(posedge clk);
        check("inst_valid_o cycles", valid_cycles - v0, 0);
        fetch_and_check(make_addr(16'h0600, 60, 3), 1'b0, 1'b1);
        finish_test("flush_during_miss", e0);
    endtask

    task automatic back_to_back_hits();
        int          e0;
        logic [31:0] addrs [32];
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            fetch_and_check(make_addr(16'h0700, 50 + i, 0), 1'b0, 1'b1);
        end
        @(negedge clk);
        for (int i = 0; i < 32; i++) begin
            addrs[i] = make_addr(16'h0700, 50 + rand_bits(2), rand_bits(3));
        end
        for (int i = 0; i <= 32; i++) begin
            @(posedge clk);
            fetch_en_i   <= (i < 32);
            uncache_i    <= 1'b0;
            fetch_addr_i <= addrs[i % 32];
            @(negedge clk);
            check("stall_o", stall_o, 1'b0);
            if (i > 0) begin
                check("inst_valid_o", inst_valid_o, 1'b1);
                check("inst_o", inst_o, mem_word(addrs[i-1]));
                check("inst_addr_o", inst_addr_o, addrs[i-1]);
            end
        end
        finish_test("back_to_back_hits", e0);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        fetch_en_i   = 1'b0;
        fetch_addr_i = '0;
        uncache_i    = 1'b0;
        flush_i      = 1'b0;
        ret_valid_i  = 1'b0;
        ret_data_i   = '0;
        uc_rvalid_i  = 1'b0;
        uc_rdata_i   = '0;
        cacop_en_i   = 1'b0;
        cacop_mode_i = CACOP_INIT;
        cacop_addr_i = '0;
        errors       = 0;
        checks       = 0;
        req_cycles   = 0;
        uc_cycles    = 0;
        valid_cycles = 0;
        lfsr_q       = 32'd88080;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        miss_then_hit();
        replacement_lru();
        uncached_fetch();
        maintenance_ops();
        flush_during_miss();
        back_to_back_hits();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- logic/icache_top.sv
`timescale 1ns/100ps

module icache_top (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          fetch_en_i,
    input  logic [31:0]                   fetch_addr_i,
    input  logic                          uncache_i,
    input  logic                          flush_i,
    output logic                          stall_o,
    output logic                          inst_valid_o,
    output logic [31:0]                   inst_o,
    output logic [31:0]                   inst_addr_o,
    output logic                          rd_req_o,
    output logic [31:0]                   rd_addr_o,
    input  logic                          ret_valid_i,
    input  logic [icache_pkg::LINE_W-1:0] ret_data_i,
    output logic                          uc_ren_o,
    output logic [31:0]                   uc_addr_o,
    input  logic                          uc_rvalid_i,
    input  logic [31:0]                   uc_rdata_i,
    input  logic                          cacop_en_i,
    input  icache_pkg::cacop_op_t         cacop_mode_i,
    input  logic [31:0]                   cacop_addr_i
);
    import icache_pkg::*;

    logic [31:0] ret_word;

    cache_array_if arr ();

    // word of the returned line for forwarding
    assign ret_word = ret_data_i[arr.word_sel * (8 << WSEL_LSB) +: 32];

    icache_ctrl u_ctrl (
        .clk          (clk),
        .reset        (reset),
        .fetch_en_i   (fetch_en_i),
        .fetch_addr_i (fetch_addr_i),
        .uncache_i    (uncache_i),
        .flush_i      (flush_i),
        .stall_o      (stall_o),
        .inst_valid_o (inst_valid_o),
        .inst_o       (inst_o),
        .inst_addr_o  (inst_addr_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .ret_valid_i  (ret_valid_i),
        .ret_word_i   (ret_word),
        .uc_ren_o     (uc_ren_o),
        .uc_addr_o    (uc_addr_o),
        .uc_rvalid_i  (uc_rvalid_i),
        .uc_rdata_i   (uc_rdata_i),
        .cacop_en_i   (cacop_en_i),
        .cacop_mode_i (cacop_mode_i),
        .cacop_addr_i (cacop_addr_i),
        .arr          (arr.ctrl)
    );

    icache_tag_array u_tag_array (
        .clk   (clk),
        .reset (reset),
        .arr   (arr.tag)
    );

    icache_data_array u_data_array (
        .clk    (clk),
        .line_i (ret_data_i),
        .arr    (arr.data)
    );

endmodule

//--- logic/icache_ctrl.sv
`timescale 1ns/100ps

module icache_ctrl (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  fetch_en_i,
    input  logic [31:0]           fetch_addr_i,
    input  logic                  uncache_i,
    input  logic                  flush_i,
    output logic                  stall_o,
    output logic                  inst_valid_o,
    output logic [31:0]           inst_o,
    output logic [31:0]           inst_addr_o,
    output logic                  rd_req_o,
    output logic [31:0]           rd_addr_o,
    input  logic                  ret_valid_i,
    input  logic [31:0]           ret_word_i,
    output logic                  uc_ren_o,
    output logic [31:0]           uc_addr_o,
    input  logic                  uc_rvalid_i,
    input  logic [31:0]           uc_rdata_i,
    input  logic                  cacop_en_i,
    input  icache_pkg::cacop_op_t cacop_mode_i,
    input  logic [31:0]           cacop_addr_i,
    cache_array_if.ctrl           arr
);
    import icache_pkg::*;

    icache_state_t   state_q, state_d;
    logic [31:0]     lkp_addr_q;
    logic            lkp_valid_q;
    logic            lkp_uc_q;
    logic            cop_rd_q;   // maintenance read cycle
    cacop_op_t       cop_op_q;
    logic [31:0]     cop_addr_q;
    logic [WAYS-1:0] cop_way_q;
    logic [31:0]     fwd_word_q;
    logic            accept;
    logic            lkp_act;
    logic            lkp_hit;
    logic            lkp_miss;
    logic            lkp_uc;
    logic            refill_wr;

    assign accept   = !stall_o;
    assign lkp_act  = (state_q == S_RUN) && lkp_valid_q && !flush_i;
    assign lkp_hit  = lkp_act && !lkp_uc_q && (|arr.hit);
    assign lkp_miss = lkp_act && !lkp_uc_q && !(|arr.hit);
    assign lkp_uc   = lkp_act && lkp_uc_q;
    assign refill_wr = (state_q == S_MISS) && ret_valid_i && !flush_i;

    // lookup stage
    always_ff @(posedge clk) begin
        if (reset) begin
            lkp_valid_q <= 1'b0;
            lkp_uc_q    <= 1'b0;
        end else if (accept) begin
            lkp_valid_q <= fetch_en_i && !cacop_en_i;  // maintenance wins
            lkp_uc_q    <= uncache_i;
        end else if (flush_i) begin
            lkp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lkp_addr_q <= fetch_addr_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cop_rd_q <= 1'b0;
        end else begin
            cop_rd_q <= accept && cacop_en_i;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && cacop_en_i) begin
            cop_op_q   <= cacop_mode_i;
            cop_addr_q <= cacop_addr_i;
        end
        if (cop_rd_q) begin
            case (cop_op_q)
                CACOP_INIT:    cop_way_q <= '1;
                CACOP_IDX_INV: cop_way_q <= WAYS'(1) << cop_addr_q[0];
                CACOP_HIT_INV: cop_way_q <= arr.hit;
                default:       cop_way_q <= '0;
            endcase
        end
    end

    // returned word is held for the delivery cycle
    always_ff @(posedge clk) begin
        if ((state_q == S_MISS) && ret_valid_i) begin
            fwd_word_q <= ret_word_i;
        end else if ((state_q == S_UNCACHE) && uc_rvalid_i) begin
            fwd_word_q <= uc_rdata_i;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_RUN: begin
                if (cop_rd_q) begin
                    state_d = S_CACOP;
                end else if (lkp_miss) begin
                    state_d = S_MISS;
                end else if (lkp_uc) begin
                    state_d = S_UNCACHE;
                end
            end
            S_MISS: begin
                if (flush_i) begin
                    state_d = ret_valid_i ? S_RUN : S_DRAIN;
                end else if (ret_valid_i) begin
                    state_d = S_REFILL;
                end
            end
            S_UNCACHE: begin
                if (flush_i) begin
                    state_d = uc_rvalid_i ? S_RUN : S_DRAIN;
                end else if (uc_rvalid_i) begin
                    state_d = S_REFILL;
                end
            end
            S_DRAIN: begin
                if (ret_valid_i || uc_rvalid_i) begin
                    state_d = S_RUN;
                end
            end
            default: state_d = S_RUN;  // S_REFILL, S_CACOP
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= S_RUN;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        case (state_q)
            S_RUN:    stall_o = cop_rd_q || lkp_miss || lkp_uc;
            S_REFILL: stall_o = 1'b0;
            default:  stall_o = 1'b1;
        endcase
    end

    assign rd_req_o  = lkp_miss || ((state_q == S_MISS) && !flush_i && !ret_valid_i);
    assign uc_ren_o  = lkp_uc || ((state_q == S_UNCACHE) && !flush_i && !uc_rvalid_i);
    assign rd_addr_o = lkp_addr_q;
    assign uc_addr_o = lkp_addr_q;

    assign inst_valid_o = lkp_hit || ((state_q == S_REFILL) && !flush_i);
    assign inst_o       = (state_q == S_REFILL) ? fwd_word_q : arr.inst;
    assign inst_addr_o  = lkp_addr_q;

    // array read side
    assign arr.rd_en    = accept;
    assign arr.rd_index = stall_o    ? lkp_addr_q[INDEX_MSB:INDEX_LSB] :
                          cacop_en_i ? cacop_addr_i[INDEX_MSB:INDEX_LSB] :
                                       fetch_addr_i[INDEX_MSB:INDEX_LSB];
    assign arr.cmp_tag  = cop_rd_q ? cop_addr_q[TAG_MSB:TAG_LSB] : lkp_addr_q[TAG_MSB:TAG_LSB];
    assign arr.word_sel = lkp_addr_q[WSEL_MSB:WSEL_LSB];

    // write side, refill or maintenance
    always_comb begin
        arr.wr_index = lkp_addr_q[INDEX_MSB:INDEX_LSB];
        arr.wr_tag   = lkp_addr_q[TAG_MSB:TAG_LSB];
        arr.wr_valid = 1'b1;
        arr.wr_way   = '0;
        if (state_q == S_CACOP) begin
            arr.wr_index = cop_addr_q[INDEX_MSB:INDEX_LSB];
            arr.wr_tag   = '0;
            arr.wr_valid = 1'b0;
            arr.wr_way   = cop_way_q;
        end else if (refill_wr) begin
            arr.wr_way = WAYS'(1) << arr.victim;
        end
    end

    assign arr.lru_touch = lkp_hit || refill_wr;
    assign arr.lru_way   = refill_wr ? arr.victim : arr.hit[1];

endmodule

//--- logic/icache_data_array.sv
`timescale 1ns/100ps

module icache_data_array (
    input  logic                          clk,
    input  logic [icache_pkg::LINE_W-1:0] line_i,
    cache_array_if.data                   arr
);
    import icache_pkg::*;

    logic [31:0] bank_mem [WAYS][BANKS][SETS];
    logic [31:0] bank_rd_q [WAYS][BANKS];
    logic        hit_way;

    // every bank of a way is written at once with the whole line
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            for (int b = 0; b < BANKS; b++) begin
                if (arr.wr_way[w]) begin
                    bank_mem[w][b][arr.wr_index] <= line_i[b*32 +: 32];
                end
                if (arr.rd_en) begin
                    bank_rd_q[w][b] <= bank_mem[w][b][arr.rd_index];
                end
            end
        end
    end

    assign hit_way = arr.hit[1];

    // word out of the registered bank outputs
    assign arr.inst = bank_rd_q[hit_way][arr.word_sel];

endmodule

//--- logic/icache_tag_array.sv
`timescale 1ns/100ps

module icache_tag_array (
    input  logic       clk,
    input  logic       reset,
    cache_array_if.tag arr
);
    import icache_pkg::*;

    logic [TAG_W-1:0] tag_mem [WAYS][SETS];
    logic [TAG_W-1:0] tag_rd_q [WAYS];
    logic [SETS-1:0]  valid_q [WAYS];
    logic [WAYS-1:0]  valid_rd_q;
    logic [SETS-1:0]  lru_q;  // way to evict next

    // tag rams, read registered on rd_en
    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (arr.wr_way[w]) begin
                tag_mem[w][arr.wr_index] <= arr.wr_tag;
            end
            if (arr.rd_en) begin
                tag_rd_q[w] <= tag_mem[w][arr.rd_index];
            end
        end
    end

    // valid bits kept in flops so reset clears them
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < WAYS; w++) begin
                valid_q[w] <= '0;
            end
            valid_rd_q <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (arr.wr_way[w]) begin
                    valid_q[w][arr.wr_index] <= arr.wr_valid;
                end
                if (arr.rd_en) begin
                    valid_rd_q[w] <= valid_q[w][arr.rd_index];
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            arr.hit[w] = valid_rd_q[w] && (tag_rd_q[w] == arr.cmp_tag);
        end
    end

    // empty ways are filled before lru is consulted
    always_comb begin
        if (!valid_q[0][arr.wr_index]) begin
            arr.victim = 1'b0;
        end else if (!valid_q[1][arr.wr_index]) begin
            arr.victim = 1'b1;
        end else begin
            arr.victim = lru_q[arr.wr_index];
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            lru_q <= '0;
        end else if (arr.lru_touch) begin
            lru_q[arr.wr_index] <= ~arr.lru_way;  // other way goes next
        end
    end

endmodule

//--- logic/cache_array_if.sv
`timescale 1ns/100ps

interface cache_array_if;
    import icache_pkg::*;

    logic                     rd_en;
    logic [INDEX_W-1:0]       rd_index;
    logic [TAG_W-1:0]         cmp_tag;
    logic [WAYS-1:0]          wr_way;    // one bit per way
    logic [INDEX_W-1:0]       wr_index;  // also picks the set for victim and lru
    logic                     wr_valid;
    logic [TAG_W-1:0]         wr_tag;
    logic                     lru_touch;
    logic                     lru_way;
    logic [$clog2(BANKS)-1:0] word_sel;
    logic [WAYS-1:0]          hit;
    logic                     victim;
    logic [31:0]              inst;

    modport ctrl (
        output rd_en, rd_index, cmp_tag, wr_way, wr_index, wr_valid, wr_tag,
               lru_touch, lru_way, word_sel,
        input  hit, victim, inst
    );

    modport tag (
        input  rd_en, rd_index, cmp_tag, wr_way, wr_index, wr_valid, wr_tag,
               lru_touch, lru_way,
        output hit, victim
    );

    modport data (
        input  rd_en, rd_index, wr_way, wr_index, word_sel, hit,
        output inst
    );

endinterface

//--- logic/icache_pkg.sv
package icache_pkg;

    // cache geometry
    localparam int WAYS     = 2;
    localparam int SETS     = 128;
    localparam int BANKS    = 8;     // 32-bit words per line
    localparam int INDEX_W  = 7;
    localparam int TAG_W    = 20;
    localparam int LINE_W   = 256;
    localparam int OFFSET_W = 5;

    // fetch address fields
    localparam int WSEL_LSB  = 2;
    localparam int WSEL_MSB  = OFFSET_W - 1;
    localparam int INDEX_LSB = OFFSET_W;
    localparam int INDEX_MSB = OFFSET_W + INDEX_W - 1;
    localparam int TAG_LSB   = OFFSET_W + INDEX_W;
    localparam int TAG_MSB   = TAG_LSB + TAG_W - 1;

    typedef enum logic [2:0] {
        S_RUN     = 3'd0,  // normal lookup
        S_MISS    = 3'd1,  // line request out
        S_REFILL  = 3'd2,  // word delivered
        S_UNCACHE = 3'd3,  // uncached request out
        S_CACOP   = 3'd4,  // maintenance write
        S_DRAIN   = 3'd5   // waiting out a flushed return
    } icache_state_t;

    // code 3 is a no-op
    typedef enum logic [1:0] {
        CACOP_INIT    = 2'd0,
        CACOP_IDX_INV = 2'd1,
        CACOP_HIT_INV = 2'd2
    } cacop_op_t;

endpackage
